/* tlb_array_pkg.sv */
// Shared TLB array sizes and types; num_pipe_stage must be at least 1 and mask_bits below entry_w
`default_nettype none

package tlb_array_pkg;

   //============================================================
   // Array dimensions
   //============================================================

   localparam int num_sets       = 16;                  // Sets in the array
   localparam int num_ways       = 4;                   // Ways per set
   localparam int set_w          = $clog2(num_sets);    // Set address width
   localparam int way_w          = $clog2(num_ways);    // Way index width
   localparam int entry_w        = 20;                  // Bits per entry

   // Read latency in stages, 1 means rd_data comes straight from stage 1
   localparam int num_pipe_stage = 2;

   // Low entry bits that never hold information
   localparam int mask_bits      = 2;

   //============================================================
   // Types
   //============================================================

   typedef logic [set_w-1:0]    set_addr_t;    // Set address
   typedef logic [num_ways-1:0] way_vec_t;     // One bit per way
   typedef logic [way_w-1:0]    way_idx_t;     // Way index
   typedef logic [entry_w-1:0]  tlb_entry_t;   // One entry

   // All ways of one set, way 0 in the low bits
   typedef tlb_entry_t [num_ways-1:0] way_entries_t;

endpackage

`default_nettype wire

/* tlb_write_stage.sv */
// Write preflop stage; loopback takes rd_data as it stands at the write edge, mask applied after the mux
`timescale 1ns/1ns
`default_nettype none

module tlb_write_stage (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        wr_en,          // Write strobe
   input  tlb_array_pkg::set_addr_t    wr_set,         // Target set
   input  tlb_array_pkg::way_vec_t     wr_way_vec,     // Ways to write
   input  tlb_array_pkg::tlb_entry_t   wr_data,        // Normal write data
   input  logic                        dfx_scan_en,    // Scan loopback mode
   input  tlb_array_pkg::way_idx_t     dfx_scan_way,   // Way taken from rd_data in scan mode
   input  tlb_array_pkg::way_entries_t rd_data,        // Current array read output
   output tlb_array_pkg::way_vec_t     commit_way_en,  // Registered per-way write enables
   output tlb_array_pkg::set_addr_t    commit_set,     // Registered set
   output tlb_array_pkg::tlb_entry_t   commit_entry    // Registered entry, shared by all ways
);

   import tlb_array_pkg::*;

   tlb_entry_t loop_entry;   // Selected way of the read output
   tlb_entry_t sel_entry;    // Loopback or normal data
   tlb_entry_t masked_entry; // Low bits cleared

   //============================================================
   // Data select and mask
   //============================================================

   // Scan mode dumps one way of the read output back into the array
   always_comb begin
      loop_entry = rd_data[dfx_scan_way];
      sel_entry  = dfx_scan_en ? loop_entry : wr_data;
   end

   // Force the unused low bits to zero so they always read back as zero
   always_comb begin
      masked_entry = sel_entry;
      for (int b = 0; b < mask_bits; b++) begin
         masked_entry[b] = 1'b0;
      end
   end

   //============================================================
   // Commit registers
   //============================================================

   // Per-way enables, the only control state here
   always_ff @(posedge clk) begin
      if (rst) begin
         commit_way_en <= '0;
      end else begin
         commit_way_en <= {num_ways{wr_en}} & wr_way_vec; // Enable gated per way
      end
   end

   // Set and entry only load on a write, one copy for all ways
   always_ff @(posedge clk) begin
      if (wr_en) begin
         commit_set   <= wr_set;
         commit_entry <= masked_entry;
      end
   end

endmodule

`default_nettype wire

/* tlb_way_store.sv */
// Flip-flop storage of all sets and ways; a same-set read and write in one cycle is not allowed
`timescale 1ns/1ns
`default_nettype none

module tlb_way_store (
   input  logic                        clk,
   input  logic                        rst,
   input  tlb_array_pkg::way_vec_t     commit_way_en,  // Per-way write enables from the preflop
   input  tlb_array_pkg::set_addr_t    commit_set,     // Set being written
   input  tlb_array_pkg::tlb_entry_t   commit_entry,   // Entry written to every enabled way
   input  logic                        rd_en,          // Read strobe
   input  tlb_array_pkg::set_addr_t    rd_set,         // Set to read
   output logic                        stage1_en,      // Stage 1 holds a new read
   output tlb_array_pkg::way_entries_t stage1_entries  // All ways of the read set
);

   import tlb_array_pkg::*;

   //============================================================
   // Storage
   //============================================================

   way_entries_t mem [num_sets];   // One row per set, all ways packed

   // Write commit, every enabled way of the committed set takes the entry
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int s = 0; s < num_sets; s++) begin
            mem[s] <= '0;
         end
      end else begin
         for (int w = 0; w < num_ways; w++) begin
            if (commit_way_en[w]) begin
               mem[commit_set][w] <= commit_entry;
            end
         end
      end
   end

   //============================================================
   // Read stage 1
   //============================================================

   // Staged read enable
   always_ff @(posedge clk) begin
      if (rst) begin
         stage1_en <= 1'b0;
      end else begin
         stage1_en <= rd_en;
      end
   end

   // Captures the row before this edge's commit lands,
   // so a write committing now is not seen by this read
   always_ff @(posedge clk) begin
      if (rst) begin
         stage1_entries <= '0;                // Zero output after reset even with one stage
      end else if (rd_en) begin
         stage1_entries <= mem[rd_set];       // Holds between reads
      end
   end

endmodule

`default_nettype wire

/* tlb_read_pipe.sv */
// Read stages 2 to num_pipe_stage; each stage loads only on its staged enable and holds otherwise
`timescale 1ns/1ns
`default_nettype none

module tlb_read_pipe (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        stage1_en,      // Stage 1 holds a new read
   input  tlb_array_pkg::way_entries_t stage1_entries, // Stage 1 read data
   output tlb_array_pkg::way_entries_t rd_data         // Final read data
);

   import tlb_array_pkg::*;

   //============================================================
   // Stage chain
   //============================================================

   if (num_pipe_stage > 1) begin : g_staged
      logic         en_q   [1:num_pipe_stage-1];  // Enable of stage k gates loading of stage k+1
      way_entries_t data_q [1:num_pipe_stage];    // Stage k read data

      assign en_q[1]   = stage1_en;
      assign data_q[1] = stage1_entries;

      for (genvar k = 2; k <= num_pipe_stage; k++) begin : g_stage
         // Data moves only with a read, so several reads can be in flight
         always_ff @(posedge clk) begin
            if (rst) begin
               data_q[k] <= '0;
            end else if (en_q[k-1]) begin
               data_q[k] <= data_q[k-1];
            end
         end

         // The last stage needs no enable of its own
         if (k < num_pipe_stage) begin : g_en
            always_ff @(posedge clk) begin
               if (rst) begin
                  en_q[k] <= 1'b0;
               end else begin
                  en_q[k] <= en_q[k-1];
               end
            end
         end
      end

      assign rd_data = data_q[num_pipe_stage];     // Output is the last stage
   end else begin : g_single
      assign rd_data = stage1_entries;            // Latency 1, stage 1 is the output
   end

endmodule

`default_nettype wire

/* tlb_array.sv */
// TLB entry array top; one read and one write port, a same-set read and write in one cycle is illegal
`timescale 1ns/1ns
`default_nettype none

module tlb_array (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        rd_en,          // Read strobe
   input  tlb_array_pkg::set_addr_t    rd_set,         // Read set
   input  logic                        wr_en,          // Write strobe
   input  tlb_array_pkg::set_addr_t    wr_set,         // Write set
   input  tlb_array_pkg::way_vec_t     wr_way_vec,     // Ways written
   input  tlb_array_pkg::tlb_entry_t   wr_data,        // Write entry
   input  logic                        dfx_scan_en,    // Loopback mode for array dump and reload
   input  tlb_array_pkg::way_idx_t     dfx_scan_way,   // Way looped back
   output tlb_array_pkg::way_entries_t rd_data         // All ways of the read set
);

   import tlb_array_pkg::*;

   //============================================================
   // Internal links
   //============================================================

   way_vec_t     commit_way_en;   // Write commit
   set_addr_t    commit_set;
   tlb_entry_t   commit_entry;
   logic         stage1_en;       // First read stage
   way_entries_t stage1_entries;

   // Write preflop with mask and loopback mux
   tlb_write_stage u_write_stage (
      .clk           (clk),
      .rst           (rst),
      .wr_en         (wr_en),
      .wr_set        (wr_set),
      .wr_way_vec    (wr_way_vec),
      .wr_data       (wr_data),
      .dfx_scan_en   (dfx_scan_en),
      .dfx_scan_way  (dfx_scan_way),
      .rd_data       (rd_data),          // Loopback from the output
      .commit_way_en (commit_way_en),
      .commit_set    (commit_set),
      .commit_entry  (commit_entry)
   );

   // Storage and read stage 1
   tlb_way_store u_way_store (
      .clk            (clk),
      .rst            (rst),
      .commit_way_en  (commit_way_en),
      .commit_set     (commit_set),
      .commit_entry   (commit_entry),
      .rd_en          (rd_en),
      .rd_set         (rd_set),
      .stage1_en      (stage1_en),
      .stage1_entries (stage1_entries)
   );

   // Remaining read stages
   tlb_read_pipe u_read_pipe (
      .clk            (clk),
      .rst            (rst),
      .stage1_en      (stage1_en),
      .stage1_entries (stage1_entries),
      .rd_data        (rd_data)
   );

endmodule

`default_nettype wire

/* tlb_array_assertions.sv */
// Bound into tlb_array; needs mask_bits of at least 1, reports only through $error
`timescale 1ns/1ns
`default_nettype none

module tlb_array_assertions (
   input logic                        clk,
   input logic                        rst,
   input logic                        rd_en,
   input tlb_array_pkg::set_addr_t    rd_set,
   input logic                        wr_en,
   input tlb_array_pkg::set_addr_t    wr_set,
   input tlb_array_pkg::way_entries_t rd_data
);

   import tlb_array_pkg::*;

   // Same-set read and write in one cycle is illegal
   no_set_conflict: assert property (@(posedge clk) disable iff (rst)
      !(rd_en && wr_en && (rd_set == wr_set)))
      else $error("read and write to set %0d in the same cycle", rd_set);

   // Low bits of every way stay clear
   for (genvar w = 0; w < num_ways; w++) begin : g_mask
      mask_low_zero: assert property (@(posedge clk) disable iff (rst)
         rd_data[w][mask_bits-1:0] == '0)
         else $error("mask bits of way %0d are set on rd_data", w);
   end

   // Output still cleared on the first edge out of reset
   zero_after_reset: assert property (@(posedge clk) $fell(rst) |-> (rd_data == '0))
      else $error("rd_data is not zero after reset");

endmodule

bind tlb_array tlb_array_assertions u_assertions (
   .clk     (clk),
   .rst     (rst),
   .rd_en   (rd_en),
   .rd_set  (rd_set),
   .wr_en   (wr_en),
   .wr_set  (wr_set),
   .rd_data (rd_data)
);

`default_nettype wire

/* tb_tlb_array.sv */
// Self-checking testbench for tlb_array; stimulus never reads and writes one set in a cycle
`timescale 1ns/1ns
`default_nettype none

module tb_tlb_array;

   import tlb_array_pkg::*;

   logic         clk;
   logic         rst;
   logic         rd_en;
   set_addr_t    rd_set;
   logic         wr_en;
   set_addr_t    wr_set;
   way_vec_t     wr_way_vec;
   tlb_entry_t   wr_data;
   logic         dfx_scan_en;
   way_idx_t     dfx_scan_way;
   way_entries_t rd_data;

   integer seed;         // Random state
   int     checks;
   int     errors;
   int     test_err0;    // Error count at start of the current test
   bit     timed_out;

   // Reference model state
   way_entries_t m_mem [num_sets];
   way_vec_t     m_pend_en;               // Write registered, lands next edge
   set_addr_t    m_pend_set;
   tlb_entry_t   m_pend_entry;
   logic         m_en   [1:num_pipe_stage];
   way_entries_t m_data [1:num_pipe_stage];   // Last stage is expected rd_data

   tlb_array UUT (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;   // 40 ns period
   end

   //============================================================
   // Reference model
   //============================================================

   function automatic tlb_entry_t cut_low_bits(input tlb_entry_t e);
      return (e >> mask_bits) << mask_bits;
   endfunction

   function automatic bit reads_in_flight();
      bit busy;
      busy = 1'b0;
      for (int k = 1; k < num_pipe_stage; k++) begin
         busy |= m_en[k];
      end
      return busy;
   endfunction

   task automatic model_reset();
      for (int s = 0; s < num_sets; s++) begin
         m_mem[s] = '0;
      end
      for (int k = 1; k <= num_pipe_stage; k++) begin
         m_en[k]   = 1'b0;
         m_data[k] = '0;
      end
      m_pend_en    = '0;
      m_pend_set   = '0;
      m_pend_entry = '0;
   endtask

   // One rising edge, every update uses pre-edge state
   task automatic model_edge();
      tlb_entry_t src;
      src = dfx_scan_en ? m_data[num_pipe_stage][dfx_scan_way] : wr_data;
      for (int k = num_pipe_stage; k >= 2; k--) begin
         if (m_en[k-1]) m_data[k] = m_data[k-1];   // Stage loads only with a read
         m_en[k] = m_en[k-1];
      end
      m_en[1] = rd_en;
      if (rd_en) m_data[1] = m_mem[rd_set];         // Sees storage before this commit
      for (int w = 0; w < num_ways; w++) begin
         if (m_pend_en[w]) m_mem[m_pend_set][w] = m_pend_entry;
      end
      m_pend_en = wr_en ? wr_way_vec : '0;
      if (wr_en) begin
         m_pend_set   = wr_set;
         m_pend_entry = cut_low_bits(src);
      end
   endtask

   //============================================================
   // Drive and check
   //============================================================

   task automatic check_output();
      way_entries_t exp;
      exp = m_data[num_pipe_stage];
      checks++;
      if (rd_data !== exp) begin
         errors++;
         $display("ERR time %0t rd_data expected %h actual %h", $time, exp, rd_data);
      end
   endtask

   // Check at the falling edge, then drive the next cycle's inputs
   task automatic step(input logic r_en, input set_addr_t r_set, input logic w_en,
                       input set_addr_t w_set, input way_vec_t w_vec, input tlb_entry_t w_data,
                       input logic s_en, input way_idx_t s_way);
      if (r_en && w_en && (r_set == w_set)) w_set = w_set + 1'b1;   // Keep off the read set
      @(negedge clk);
      check_output();
      rd_en        = r_en;
      rd_set       = r_set;
      wr_en        = w_en;
      wr_set       = w_set;
      wr_way_vec   = w_vec;
      wr_data      = w_data;
      dfx_scan_en  = s_en;
      dfx_scan_way = s_way;
      @(posedge clk);
      model_edge();
   endtask

   task automatic idle();
      step(1'b0, '0, 1'b0, '0, '0, '0, 1'b0, '0);
   endtask

   // Let in-flight reads reach the output, then report the test
   task automatic finish_test(input string name);
      int cnt;
      cnt = 0;
      while (reads_in_flight() && cnt < 4 * num_pipe_stage) begin
         idle();
         cnt++;
      end
      if (reads_in_flight()) begin
         $display("Timeout in test %s, read pipeline did not drain", name);
         timed_out = 1'b1;
      end
      idle();                                           // Checks the final output
      $display("test %-12s done, %0d errors", name, errors - test_err0);
      test_err0 = errors;
   endtask

   //============================================================
   // Tests
   //============================================================

   initial begin
      set_addr_t  rs;
      set_addr_t  ws;
      set_addr_t  last_ws;
      tlb_entry_t ent;
      logic       we;
      seed = 32'h23bb85f2;
      checks = 0;
      errors = 0;
      test_err0 = 0;
      timed_out = 1'b0;
      last_ws = '0;
      rst = 1'b1;
      rd_en = 1'b0;
      rd_set = '0;
      wr_en = 1'b0;
      wr_set = '0;
      wr_way_vec = '0;
      wr_data = '0;
      dfx_scan_en = 1'b0;
      dfx_scan_way = '0;
      model_reset();
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(posedge clk);
      model_edge();

      for (int s = 0; s < num_sets; s++) step(1'b1, s, 1'b0, '0, '0, '0, 1'b0, '0);
      finish_test("reset_reads");

      // Read every cycle, write about half of them
      for (int i = 0; i < 400; i++) begin
         rs = $random(seed);
         if (($random(seed) & 3) == 0) rs = last_ws;    // Read right after a same-set write
         we  = $random(seed);
         ws  = $random(seed);
         ent = $random(seed);
         step(1'b1, rs, we, ws, way_vec_t'($random(seed)), ent, 1'b0, '0);
         if (we) last_ws = ws;
      end
      finish_test("random");

      for (int w = 0; w < num_ways; w++) begin
         step(1'b0, '0, 1'b1, 5, way_vec_t'(1 << w), $random(seed), 1'b0, '0);
      end
      step(1'b0, '0, 1'b1, 5, way_vec_t'(5), $random(seed), 1'b0, '0);   // Ways 0 and 2
      idle();
      step(1'b1, 5, 1'b1, 5 + 1, way_vec_t'(14), $random(seed), 1'b0, '0);
      idle();
      step(1'b1, 5 + 1, 1'b0, '0, '0, '0, 1'b0, '0);
      finish_test("multi_way");

      for (int s = 0; s < 4; s++) begin
         ent = tlb_entry_t'($random(seed)) | tlb_entry_t'((1 << mask_bits) - 1);
         step(1'b0, '0, 1'b1, s, '1, ent, 1'b0, '0);
         idle();
         step(1'b1, s, 1'b0, '0, '0, '0, 1'b0, '0);
      end
      finish_test("mask");

      // Loop each way of the read output back into a fresh set
      for (int w = 0; w < num_ways; w++) begin
         step(1'b0, '0, 1'b1, 3, way_vec_t'(1 << w), $random(seed), 1'b0, '0);
      end
      idle();
      for (int w = 0; w < num_ways; w++) begin
         step(1'b1, 3, 1'b0, '0, '0, '0, 1'b0, '0);                  // Set 3 back on rd_data
         idle();
         step(1'b0, '0, 1'b1, 8 + w, '1, $random(seed), 1'b1, w);   // wr_data ignored
         idle();
         step(1'b1, 8 + w, 1'b0, '0, '0, '0, 1'b0, '0);
      end
      finish_test("loopback");

      // rd_set stays on the last read set while rd_en is low
      step(1'b1, 6, 1'b0, '0, '0, '0, 1'b0, '0);
      for (int i = 0; i < 30; i++) begin
         ws = (i % 3 == 0) ? set_addr_t'(6) : set_addr_t'($random(seed));
         step(1'b0, 6, 1'b1, ws, way_vec_t'($random(seed)), $random(seed), 1'b0, '0);
      end
      finish_test("hold");

      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
      if (errors == 0 && !timed_out) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tlb_array.f */
tlb_array_pkg.sv
tlb_write_stage.sv
tlb_way_store.sv
tlb_read_pipe.sv
tlb_array.sv
tlb_array_assertions.sv
tb_tlb_array.sv

/* Bender.yml */
package:
  name: tlb_array

sources:
  # RTL in compile order
  - files:
      - tlb_array_pkg.sv
      - tlb_write_stage.sv
      - tlb_way_store.sv
      - tlb_read_pipe.sv
      - tlb_array.sv
  # Testbench and bound assertions
  - target: test
    files:
      - tlb_array_assertions.sv
      - tb_tlb_array.sv
